// ==== Makefile ====
# Verilator build and regression run for the issue stage

VERILATOR ?= verilator
TOP       ?= tb_issue_stage
FILELIST  ?= sources.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
PASS_MSG  := Regression passed

.PHONY: help build test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the regression, check $(LOG)"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "variables: VERILATOR TOP FILELIST BUILD_DIR LOG"

build:
	$(VERILATOR) --binary --timing --assert -f $(FILELIST) \
		--top-module $(TOP) --Mdir $(BUILD_DIR)

test: build
	@./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -qx "$(PASS_MSG)" $(LOG); then echo "PASS"; else echo "FAIL"; exit 1; fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== bench/issue_stage_checker.sv ====
`timescale 1ns/10ps
`default_nettype none

module issue_stage_checker (
    input wire logic clk_i,
    input wire logic rst_ni,
    input wire logic flush_i,
    input wire logic issue_valid_i,
    input wire logic issue_ack_o,
    input wire logic alu_valid_o,
    input wire logic branch_valid_o,
    input wire logic lsu_valid_o,
    input wire logic mult_valid_o
);

    logic [3:0] valids;

    assign valids = {mult_valid_o, lsu_valid_o, branch_valid_o, alu_valid_o};

    // ------------------------------------------------------------------------
    // unit valid lines
    // ------------------------------------------------------------------------
    // one registered entry can only target one unit
    valid_onehot: assert property (@(posedge clk_i) disable iff (!rst_ni) $onehot0(valids))
        else $error("more than one unit valid is high");

    // flush kills the entry captured on the same edge
    flush_kills_valid: assert property (@(posedge clk_i) disable iff (!rst_ni)
        flush_i |=> valids == '0)
        else $error("unit valid high in the cycle after flush");

    // every valid comes from an accepting edge
    valid_needs_accept: assert property (@(posedge clk_i) disable iff (!rst_ni)
        (|valids) |-> $past(issue_valid_i && issue_ack_o))
        else $error("unit valid high without a preceding accept");

endmodule

`default_nettype wire

// ==== bench/tb_issue_stage.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "issue_settings.svh"

module tb_issue_stage;

    localparam int unsigned SEED        = 32'h4046_57d0;
    localparam int unsigned NR_PORTS    = `ISSUE_NR_COMMIT_PORTS;
    localparam int unsigned NR_REGS     = 2**`ISSUE_REG_ADDR_W;
    // accepted instructions per test
    localparam int unsigned PER_TEST    = 250;
    // four tests plus reset and drain
    localparam int unsigned STIM_CYCLES = 4*PER_TEST + 7;
    localparam int unsigned CYCLE_LIMIT = 4*STIM_CYCLES + 100;

    logic clk_i;
    logic rst_ni;
    logic flush_i;
    issue_pkg::issue_entry_t                       issue_instr_i;
    logic                                          issue_valid_i;
    logic                                          issue_ack_o;
    isa_pkg::reg_addr_t                            rs1_o;
    isa_pkg::reg_addr_t                            rs2_o;
    isa_pkg::xlen_t                                rs1_fwd_i;
    isa_pkg::xlen_t                                rs2_fwd_i;
    logic                                          rs1_fwd_valid_i;
    logic                                          rs2_fwd_valid_i;
    issue_pkg::clobber_map_t                       clobber_i;
    issue_pkg::commit_port_t [NR_PORTS-1:0]        commit_i;
    issue_pkg::fu_data_t                           fu_data_o;
    logic alu_ready_i;
    logic lsu_ready_i;
    logic alu_valid_o;
    logic branch_valid_o;
    logic lsu_valid_o;
    logic mult_valid_o;

    // reference model state
    isa_pkg::xlen_t      model_rf [NR_REGS];
    logic                exp_issued;
    issue_pkg::fu_data_t exp_data;
    logic                hold_instr;
    int unsigned         cycle_count;
    int unsigned         seed_value;

    issue_stage uut (
        .clk_i           (clk_i),
        .rst_ni          (rst_ni),
        .flush_i         (flush_i),
        .issue_instr_i   (issue_instr_i),
        .issue_valid_i   (issue_valid_i),
        .issue_ack_o     (issue_ack_o),
        .rs1_o           (rs1_o),
        .rs1_fwd_i       (rs1_fwd_i),
        .rs1_fwd_valid_i (rs1_fwd_valid_i),
        .rs2_o           (rs2_o),
        .rs2_fwd_i       (rs2_fwd_i),
        .rs2_fwd_valid_i (rs2_fwd_valid_i),
        .clobber_i       (clobber_i),
        .commit_i        (commit_i),
        .fu_data_o       (fu_data_o),
        .alu_ready_i     (alu_ready_i),
        .lsu_ready_i     (lsu_ready_i),
        .alu_valid_o     (alu_valid_o),
        .branch_valid_o  (branch_valid_o),
        .lsu_valid_o     (lsu_valid_o),
        .mult_valid_o    (mult_valid_o)
    );

    bind issue_stage issue_stage_checker i_checker (
        .clk_i          (clk_i),
        .rst_ni         (rst_ni),
        .flush_i        (flush_i),
        .issue_valid_i  (issue_valid_i),
        .issue_ack_o    (issue_ack_o),
        .alu_valid_o    (alu_valid_o),
        .branch_valid_o (branch_valid_o),
        .lsu_valid_o    (lsu_valid_o),
        .mult_valid_o   (mult_valid_o)
    );

    // 4 ns period
    always #2 clk_i = ~clk_i;

    always @(posedge clk_i) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= CYCLE_LIMIT) begin
            $display("timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
            $display("Regression failed");
            $fatal(1, "cycle limit reached");
        end
    end

    task automatic check_value(input string name, input logic [63:0] expected,
                               input logic [63:0] actual);
        if (actual !== expected) begin
            $display("ERR %s expected %h actual %h", name, expected, actual);
            $display("Regression failed");
            $fatal(1, "stopped at first mismatch");
        end
    endtask

    // ------------------------------------------------------------------------
    // registered side one cycle after the accepting edge
    // ------------------------------------------------------------------------
    task automatic check_outputs(input string name);
        logic [3:0] exp_valid;
        exp_valid[0] = exp_issued && exp_data.fu == isa_pkg::ALU;
        exp_valid[1] = exp_issued && exp_data.fu == isa_pkg::CTRL_FLOW;
        exp_valid[2] = exp_issued &&
                       (exp_data.fu == isa_pkg::LOAD || exp_data.fu == isa_pkg::STORE);
        exp_valid[3] = exp_issued && exp_data.fu == isa_pkg::MULT;
        check_value({name, " valids"}, 64'(exp_valid),
                    64'({mult_valid_o, lsu_valid_o, branch_valid_o, alu_valid_o}));
        // payload only matters while a unit valid is up
        if (|exp_valid) begin
            check_value({name, " fu"}, 64'(exp_data.fu), 64'(fu_data_o.fu));
            check_value({name, " operand_a"}, exp_data.operand_a, fu_data_o.operand_a);
            check_value({name, " operand_b"}, exp_data.operand_b, fu_data_o.operand_b);
            check_value({name, " imm"}, exp_data.imm, fu_data_o.imm);
            check_value({name, " trans_id"}, 64'(exp_data.trans_id), 64'(fu_data_o.trans_id));
            check_value({name, " op"}, 64'(exp_data.op), 64'(fu_data_o.op));
        end
    endtask

    // ------------------------------------------------------------------------
    // random stimulus
    // ------------------------------------------------------------------------
    // mode 0 regfile, mode 1 forward, mode 2 waw, mode 3 mixed
    task automatic drive_inputs(input int mode);
        issue_pkg::issue_entry_t ins;
        // an unacked instruction stays on the bus
        if (!hold_instr) begin
            ins.pc       = isa_pkg::vaddr_t'({$urandom, $urandom});
            ins.trans_id = isa_pkg::trans_id_t'($urandom);
            ins.fu       = isa_pkg::fu_t'(3'($urandom_range(5, 0)));
            ins.op       = isa_pkg::fu_op_t'(4'($urandom_range(12, 0)));
            ins.rs1      = isa_pkg::reg_addr_t'($urandom);
            ins.rs2      = isa_pkg::reg_addr_t'($urandom);
            ins.rd       = isa_pkg::reg_addr_t'($urandom);
            ins.result   = {$urandom, $urandom};
            ins.use_imm  = 1'($urandom);
            ins.use_pc   = $urandom_range(3, 0) == 0;
            issue_instr_i = ins;
            issue_valid_i = $urandom_range(7, 0) != 0;
        end
        for (int r = 0; r < NR_REGS; r++) begin
            if (mode != 0 && $urandom_range(2, 0) == 0) begin
                clobber_i[r] = isa_pkg::fu_t'(3'($urandom_range(5, 1)));
            end else begin
                clobber_i[r] = isa_pkg::NONE;
            end
        end
        rs1_fwd_i       = {$urandom, $urandom};
        rs2_fwd_i       = {$urandom, $urandom};
        rs1_fwd_valid_i = mode == 0 || $urandom_range(3, 0) != 0;
        rs2_fwd_valid_i = mode == 0 || $urandom_range(3, 0) != 0;
        for (int p = 0; p < NR_PORTS; p++) begin
            commit_i[p].we    = 1'($urandom);
            commit_i[p].waddr = isa_pkg::reg_addr_t'($urandom);
            commit_i[p].wdata = {$urandom, $urandom};
            // aim commits at rd to open the WAW bypass
            if (mode == 2 && $urandom_range(1, 0) == 0) begin
                commit_i[p].waddr = issue_instr_i.rd;
            end
        end
        // two ports on one register now and then
        if ($urandom_range(7, 0) == 0) begin
            commit_i[NR_PORTS-1].waddr = commit_i[0].waddr;
        end
        alu_ready_i = mode != 3 || $urandom_range(3, 0) != 0;
        lsu_ready_i = mode != 3 || $urandom_range(3, 0) != 0;
        flush_i     = mode == 3 && $urandom_range(7, 0) == 0;
    endtask

    // ------------------------------------------------------------------------
    // reference model for ack and operands of the current cycle
    // ------------------------------------------------------------------------
    task automatic predict_and_check(input string name, output logic accepted);
        logic                pend_a;
        logic                pend_b;
        logic                stall;
        logic                rd_free;
        logic                busy;
        logic                ack;
        issue_pkg::fu_data_t d;
        pend_a = clobber_i[issue_instr_i.rs1] != isa_pkg::NONE && issue_instr_i.rs1 != '0;
        pend_b = clobber_i[issue_instr_i.rs2] != isa_pkg::NONE && issue_instr_i.rs2 != '0;
        stall  = (pend_a && !rs1_fwd_valid_i) || (pend_b && !rs2_fwd_valid_i);
        rd_free = clobber_i[issue_instr_i.rd] == isa_pkg::NONE;
        for (int p = 0; p < NR_PORTS; p++) begin
            if (commit_i[p].we && commit_i[p].waddr == issue_instr_i.rd) begin
                rd_free = 1'b1;
            end
        end
        case (issue_instr_i.fu)
            isa_pkg::ALU, isa_pkg::CTRL_FLOW, isa_pkg::MULT: busy = !alu_ready_i;
            isa_pkg::LOAD, isa_pkg::STORE:                   busy = !lsu_ready_i;
            default:                                         busy = 1'b0;
        endcase
        // multiply issued last cycle lets only a multiply through
        if (exp_issued && exp_data.fu == isa_pkg::MULT && issue_instr_i.fu != isa_pkg::MULT) begin
            busy = 1'b1;
        end
        ack = issue_valid_i && !busy &&
              (issue_instr_i.fu == isa_pkg::NONE || (!stall && rd_free));
        check_value({name, " ack"}, 64'(ack), 64'(issue_ack_o));
        check_value({name, " rs1"}, 64'(issue_instr_i.rs1), 64'(rs1_o));
        check_value({name, " rs2"}, 64'(issue_instr_i.rs2), 64'(rs2_o));

        d.fu       = issue_instr_i.fu;
        d.op       = issue_instr_i.op;
        d.trans_id = issue_instr_i.trans_id;
        d.imm      = issue_instr_i.result;
        if (issue_instr_i.use_pc) begin
            d.operand_a = isa_pkg::xlen_t'($signed(issue_instr_i.pc));
        end else begin
            d.operand_a = pend_a ? rs1_fwd_i : model_rf[issue_instr_i.rs1];
        end
        if (issue_instr_i.use_imm && issue_instr_i.fu != isa_pkg::STORE &&
            issue_instr_i.fu != isa_pkg::CTRL_FLOW) begin
            d.operand_b = issue_instr_i.result;
        end else begin
            d.operand_b = pend_b ? rs2_fwd_i : model_rf[issue_instr_i.rs2];
        end

        // state after the coming edge
        exp_issued = ack && !flush_i;
        exp_data   = d;
        for (int p = 0; p < NR_PORTS; p++) begin
            if (commit_i[p].we && commit_i[p].waddr != '0) begin
                model_rf[commit_i[p].waddr] = commit_i[p].wdata;
            end
        end
        hold_instr = issue_valid_i && !ack;
        accepted   = ack;
    endtask

    task automatic run_test(input string name, input int mode);
        int unsigned accepted;
        logic        ack;
        accepted = 0;
        while (accepted < PER_TEST) begin
            @(negedge clk_i);
            check_outputs(name);
            drive_inputs(mode);
            #1;
            predict_and_check(name, ack);
            if (ack) begin
                accepted++;
            end
        end
    endtask

    initial begin
        seed_value      = $urandom(SEED);
        cycle_count     = 0;
        clk_i           = 1'b0;
        rst_ni          = 1'b0;
        flush_i         = 1'b0;
        issue_instr_i   = '0;
        issue_valid_i   = 1'b0;
        rs1_fwd_i       = '0;
        rs2_fwd_i       = '0;
        rs1_fwd_valid_i = 1'b0;
        rs2_fwd_valid_i = 1'b0;
        clobber_i       = '0;
        commit_i        = '0;
        alu_ready_i     = 1'b1;
        lsu_ready_i     = 1'b1;
        for (int r = 0; r < NR_REGS; r++) begin
            model_rf[r] = '0;
        end
        exp_issued = 1'b0;
        exp_data   = '0;
        hold_instr = 1'b0;

        repeat (5) @(posedge clk_i);
        @(negedge clk_i);
        rst_ni = 1'b1;
        #1;
        // idle after reset
        check_value("reset ack", 64'(0), 64'(issue_ack_o));
        check_outputs("reset");

        run_test("regfile", 0);
        run_test("forward", 1);
        run_test("waw", 2);
        run_test("mixed", 3);

        // last accepted entry
        @(negedge clk_i);
        check_outputs("drain");
        issue_valid_i = 1'b0;
        $display("Regression passed");
        $finish;
    end

endmodule

`default_nettype wire

// ==== sources.f ====
+incdir+verilog
verilog/isa_pkg.sv
verilog/issue_pkg.sv
verilog/int_regfile.sv
verilog/operand_fetch.sv
verilog/issue_register.sv
verilog/fu_dispatch.sv
verilog/issue_stage.sv
bench/issue_stage_checker.sv
bench/tb_issue_stage.sv

// ==== verilog/fu_dispatch.sv ====
`timescale 1ns/10ps
`default_nettype none

module fu_dispatch (
    input  wire issue_pkg::fu_data_t data_i,
    input  wire logic                issued_i,
    // unit of the instruction currently waiting for ack
    input  wire isa_pkg::fu_t        req_fu_i,
    input  wire logic                alu_ready_i,
    input  wire logic                lsu_ready_i,
    output      logic                alu_valid_o,
    output      logic                branch_valid_o,
    output      logic                lsu_valid_o,
    output      logic                mult_valid_o,
    output      logic                unit_busy_o
);

    logic ready_busy;

    // ------------------------------------------------------------------------
    // valid decode of the registered entry
    // ------------------------------------------------------------------------
    assign alu_valid_o    = issued_i && (data_i.fu == isa_pkg::ALU);
    assign branch_valid_o = issued_i && (data_i.fu == isa_pkg::CTRL_FLOW);
    assign lsu_valid_o    = issued_i &&
                            (data_i.fu == isa_pkg::LOAD || data_i.fu == isa_pkg::STORE);
    assign mult_valid_o   = issued_i && (data_i.fu == isa_pkg::MULT);

    // ------------------------------------------------------------------------
    // busy for the requested unit
    // ------------------------------------------------------------------------
    always_comb begin : busy_select
        case (req_fu_i)
            // fixed latency units share one result path
            isa_pkg::ALU, isa_pkg::CTRL_FLOW, isa_pkg::MULT: ready_busy = !alu_ready_i;
            isa_pkg::LOAD, isa_pkg::STORE:                   ready_busy = !lsu_ready_i;
            default:                                         ready_busy = 1'b0;
        endcase
    end

    // a multiply in flight only lets another multiply follow,
    // otherwise both would hit the fixed latency bus together
    assign unit_busy_o = ready_busy || (mult_valid_o && req_fu_i != isa_pkg::MULT);

endmodule

`default_nettype wire

// ==== verilog/int_regfile.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "issue_settings.svh"

module int_regfile (
    input  wire logic                                                clk_i,
    input  wire logic                                                rst_ni,
    input  wire isa_pkg::reg_addr_t [1:0]                            raddr_i,
    input  wire issue_pkg::commit_port_t [`ISSUE_NR_COMMIT_PORTS-1:0] commit_i,
    output      isa_pkg::xlen_t [1:0]                                rdata_o
);

    isa_pkg::xlen_t regs_q [0:2**`ISSUE_REG_ADDR_W-1];

    // x0 is a constant, not a flop
    assign regs_q[0] = '0;

    // ------------------------------------------------------------------------
    // write side
    // ------------------------------------------------------------------------
    for (genvar r = 1; r < 2**`ISSUE_REG_ADDR_W; r++) begin : gen_reg
        always_ff @(posedge clk_i or negedge rst_ni) begin
            if (!rst_ni) begin
                regs_q[r] <= '0;
            end else begin
                // later ports overwrite earlier ones, so the highest port wins
                for (int p = 0; p < `ISSUE_NR_COMMIT_PORTS; p++) begin
                    if (commit_i[p].we && commit_i[p].waddr == isa_pkg::reg_addr_t'(r)) begin
                        regs_q[r] <= commit_i[p].wdata;
                    end
                end
            end
        end
    end

    // ------------------------------------------------------------------------
    // read side
    // ------------------------------------------------------------------------
    // plain asynchronous read, commits show up one cycle later
    assign rdata_o[0] = regs_q[raddr_i[0]];
    assign rdata_o[1] = regs_q[raddr_i[1]];

endmodule

`default_nettype wire

// ==== verilog/isa_pkg.sv ====
`default_nettype none

`include "issue_settings.svh"

package isa_pkg;

    // ------------------------------------------------------------------------
    // architectural widths
    // ------------------------------------------------------------------------
    typedef logic [`ISSUE_XLEN-1:0]       xlen_t;
    typedef logic [`ISSUE_REG_ADDR_W-1:0] reg_addr_t;
    typedef logic [`ISSUE_VLEN-1:0]       vaddr_t;
    typedef logic [`ISSUE_TRANS_ID_W-1:0] trans_id_t;

    // ------------------------------------------------------------------------
    // functional units and operators
    // ------------------------------------------------------------------------
    // NONE also marks a free register in the clobber map
    typedef enum logic [2:0] {
        NONE,
        ALU,
        CTRL_FLOW,
        LOAD,
        STORE,
        MULT
    } fu_t;

    typedef enum logic [3:0] {
        // arithmetic and logic
        ADD, SUB, AND, OR, XOR, SLL, SRL,
        // multiplier
        MUL,
        // memory
        LD, SD,
        // branches and jumps
        BEQ, BNE, JALR
    } fu_op_t;

endpackage

`default_nettype wire

// ==== verilog/issue_pkg.sv ====
`default_nettype none

`include "issue_settings.svh"

package issue_pkg;

    // decoded instruction as handed over by the scoreboard
    typedef struct packed {
        isa_pkg::vaddr_t    pc;
        isa_pkg::trans_id_t trans_id;
        isa_pkg::fu_t       fu;
        isa_pkg::fu_op_t    op;
        isa_pkg::reg_addr_t rs1;
        isa_pkg::reg_addr_t rs2;
        isa_pkg::reg_addr_t rd;
        // immediate of the instruction
        isa_pkg::xlen_t     result;
        logic               use_imm;
        logic               use_pc;
    } issue_entry_t;

    // operands and control for the execute stage
    typedef struct packed {
        isa_pkg::fu_t       fu;
        isa_pkg::fu_op_t    op;
        isa_pkg::xlen_t     operand_a;
        isa_pkg::xlen_t     operand_b;
        isa_pkg::xlen_t     imm;
        isa_pkg::trans_id_t trans_id;
    } fu_data_t;

    // one integer write port of the commit stage
    typedef struct packed {
        logic               we;
        isa_pkg::reg_addr_t waddr;
        isa_pkg::xlen_t     wdata;
    } commit_port_t;

    // pending writer per register, NONE means no write outstanding
    typedef isa_pkg::fu_t [2**`ISSUE_REG_ADDR_W-1:0] clobber_map_t;

endpackage

`default_nettype wire

// ==== verilog/issue_register.sv ====
`timescale 1ns/10ps
`default_nettype none

module issue_register (
    input  wire logic                clk_i,
    input  wire logic                rst_ni,
    input  wire logic                flush_i,
    input  wire issue_pkg::fu_data_t next_data_i,
    // instruction handed over on this edge
    input  wire logic                accept_i,
    output      issue_pkg::fu_data_t data_o,
    output      logic                issued_o
);

    // ------------------------------------------------------------------------
    // ID/EX operand register
    // ------------------------------------------------------------------------
    // loaded every cycle, only meaningful while issued_o is high
    always_ff @(posedge clk_i) begin : payload_reg
        data_o <= next_data_i;
    end

    // ------------------------------------------------------------------------
    // issued flag
    // ------------------------------------------------------------------------
    always_ff @(posedge clk_i or negedge rst_ni) begin : issued_reg
        if (!rst_ni) begin
            issued_o <= 1'b0;
        end else begin
            // a flush kills the entry even when it is accepted on the same edge
            issued_o <= accept_i && !flush_i;
        end
    end

endmodule

`default_nettype wire

// ==== verilog/issue_settings.svh ====
`ifndef ISSUE_SETTINGS_SVH
`define ISSUE_SETTINGS_SVH

// integer data path width
`define ISSUE_XLEN 64

// architectural register index, 32 integer registers
`define ISSUE_REG_ADDR_W 5

// write ports from the commit stage
`define ISSUE_NR_COMMIT_PORTS 2

// scoreboard slot index
`define ISSUE_TRANS_ID_W 3

// virtual PC width, sign-extended to XLEN when used as operand
`define ISSUE_VLEN 39

`endif

// ==== verilog/issue_stage.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "issue_settings.svh"

module issue_stage (
    input  wire logic                                                clk_i,
    input  wire logic                                                rst_ni,
    input  wire logic                                                flush_i,
    // issue handshake
    input  wire issue_pkg::issue_entry_t                             issue_instr_i,
    input  wire logic                                                issue_valid_i,
    output      logic                                                issue_ack_o,
    // scoreboard lookup
    output      isa_pkg::reg_addr_t                                  rs1_o,
    input  wire isa_pkg::xlen_t                                      rs1_fwd_i,
    input  wire logic                                                rs1_fwd_valid_i,
    output      isa_pkg::reg_addr_t                                  rs2_o,
    input  wire isa_pkg::xlen_t                                      rs2_fwd_i,
    input  wire logic                                                rs2_fwd_valid_i,
    input  wire issue_pkg::clobber_map_t                             clobber_i,
    // commit write ports
    input  wire issue_pkg::commit_port_t [`ISSUE_NR_COMMIT_PORTS-1:0] commit_i,
    // functional units
    output      issue_pkg::fu_data_t                                 fu_data_o,
    input  wire logic                                                alu_ready_i,
    input  wire logic                                                lsu_ready_i,
    output      logic                                                alu_valid_o,
    output      logic                                                branch_valid_o,
    output      logic                                                lsu_valid_o,
    output      logic                                                mult_valid_o
);

    issue_pkg::fu_data_t next_data;
    logic                issued;
    logic                unit_busy;

    operand_fetch i_operand_fetch (
        .clk_i           (clk_i),
        .rst_ni          (rst_ni),
        .issue_instr_i   (issue_instr_i),
        .issue_valid_i   (issue_valid_i),
        .rs1_fwd_i       (rs1_fwd_i),
        .rs1_fwd_valid_i (rs1_fwd_valid_i),
        .rs2_fwd_i       (rs2_fwd_i),
        .rs2_fwd_valid_i (rs2_fwd_valid_i),
        .clobber_i       (clobber_i),
        .commit_i        (commit_i),
        .unit_busy_i     (unit_busy),
        .rs1_o           (rs1_o),
        .rs2_o           (rs2_o),
        .issue_ack_o     (issue_ack_o),
        .next_data_o     (next_data)
    );

    // ack already implies valid, so it marks the accepting edge
    issue_register i_issue_register (
        .clk_i       (clk_i),
        .rst_ni      (rst_ni),
        .flush_i     (flush_i),
        .next_data_i (next_data),
        .accept_i    (issue_ack_o),
        .data_o      (fu_data_o),
        .issued_o    (issued)
    );

    fu_dispatch i_fu_dispatch (
        .data_i         (fu_data_o),
        .issued_i       (issued),
        .req_fu_i       (issue_instr_i.fu),
        .alu_ready_i    (alu_ready_i),
        .lsu_ready_i    (lsu_ready_i),
        .alu_valid_o    (alu_valid_o),
        .branch_valid_o (branch_valid_o),
        .lsu_valid_o    (lsu_valid_o),
        .mult_valid_o   (mult_valid_o),
        .unit_busy_o    (unit_busy)
    );

endmodule

`default_nettype wire

// ==== verilog/operand_fetch.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "issue_settings.svh"

module operand_fetch (
    input  wire logic                                                clk_i,
    input  wire logic                                                rst_ni,
    // instruction from the scoreboard
    input  wire issue_pkg::issue_entry_t                             issue_instr_i,
    input  wire logic                                                issue_valid_i,
    // forwarded results for rs1_o / rs2_o
    input  wire isa_pkg::xlen_t                                      rs1_fwd_i,
    input  wire logic                                                rs1_fwd_valid_i,
    input  wire isa_pkg::xlen_t                                      rs2_fwd_i,
    input  wire logic                                                rs2_fwd_valid_i,
    input  wire issue_pkg::clobber_map_t                             clobber_i,
    input  wire issue_pkg::commit_port_t [`ISSUE_NR_COMMIT_PORTS-1:0] commit_i,
    // requested unit cannot take work
    input  wire logic                                                unit_busy_i,
    output      isa_pkg::reg_addr_t                                  rs1_o,
    output      isa_pkg::reg_addr_t                                  rs2_o,
    output      logic                                                issue_ack_o,
    output      issue_pkg::fu_data_t                                 next_data_o
);

    logic                     fwd_rs1;
    logic                     fwd_rs2;
    logic                     stall;
    logic                     rd_free;
    isa_pkg::reg_addr_t [1:0] rf_raddr;
    isa_pkg::xlen_t [1:0]     rf_rdata;

    // scoreboard lookup uses the raw source indices
    assign rs1_o = issue_instr_i.rs1;
    assign rs2_o = issue_instr_i.rs2;

    // ------------------------------------------------------------------------
    // RAW hazards: read, forward or stall
    // ------------------------------------------------------------------------
    always_comb begin : raw_check
        fwd_rs1 = 1'b0;
        fwd_rs2 = 1'b0;
        stall   = 1'b0;
        // x0 never waits on a writer
        if (clobber_i[issue_instr_i.rs1] != isa_pkg::NONE && issue_instr_i.rs1 != '0) begin
            if (rs1_fwd_valid_i) begin
                fwd_rs1 = 1'b1;
            end else begin
                stall = 1'b1;
            end
        end
        if (clobber_i[issue_instr_i.rs2] != isa_pkg::NONE && issue_instr_i.rs2 != '0) begin
            if (rs2_fwd_valid_i) begin
                fwd_rs2 = 1'b1;
            end else begin
                stall = 1'b1;
            end
        end
    end

    // ------------------------------------------------------------------------
    // WAW: rd must be free or be retired by a commit port right now
    // ------------------------------------------------------------------------
    always_comb begin : waw_check
        rd_free = (clobber_i[issue_instr_i.rd] == isa_pkg::NONE);
        for (int p = 0; p < `ISSUE_NR_COMMIT_PORTS; p++) begin
            if (commit_i[p].we && commit_i[p].waddr == issue_instr_i.rd) begin
                rd_free = 1'b1;
            end
        end
    end

    // a unit-less instruction only waits on the multiply rule,
    // which is folded into unit_busy_i
    assign issue_ack_o = issue_valid_i && !unit_busy_i &&
                         (issue_instr_i.fu == isa_pkg::NONE || (!stall && rd_free));

    // ------------------------------------------------------------------------
    // integer register file
    // ------------------------------------------------------------------------
    assign rf_raddr = {issue_instr_i.rs2, issue_instr_i.rs1};

    int_regfile i_int_regfile (
        .clk_i    (clk_i),
        .rst_ni   (rst_ni),
        .raddr_i  (rf_raddr),
        .commit_i (commit_i),
        .rdata_o  (rf_rdata)
    );

    // ------------------------------------------------------------------------
    // operand mux
    // ------------------------------------------------------------------------
    always_comb begin : operand_select
        next_data_o.fu        = issue_instr_i.fu;
        next_data_o.op        = issue_instr_i.op;
        next_data_o.trans_id  = issue_instr_i.trans_id;
        next_data_o.imm       = issue_instr_i.result;
        next_data_o.operand_a = fwd_rs1 ? rs1_fwd_i : rf_rdata[0];
        next_data_o.operand_b = fwd_rs2 ? rs2_fwd_i : rf_rdata[1];
        // pc as operand a, sign extended
        if (issue_instr_i.use_pc) begin
            next_data_o.operand_a = {{(`ISSUE_XLEN-`ISSUE_VLEN){issue_instr_i.pc[`ISSUE_VLEN-1]}},
                                     issue_instr_i.pc};
        end
        // stores and branches need rs2 as data / compare value
        if (issue_instr_i.use_imm && issue_instr_i.fu != isa_pkg::STORE &&
            issue_instr_i.fu != isa_pkg::CTRL_FLOW) begin
            next_data_o.operand_b = issue_instr_i.result;
        end
    end

endmodule

`default_nettype wire
